/* include/bp_defines.svh */
// Width macros shared by the gshare direction predictor, included by packages and RTL
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// ------------------------------
// Address and history sizing
// ------------------------------

// Fetch and branch virtual address width
`define BP_ADDR_W 32

// Global history length in outcomes
`define BP_HIST_W 8

// ------------------------------
// Table sizing
// ------------------------------

// Counter table index width
// Must match BP_HIST_W, the hash is a plain XOR of the two
`define BP_IDX_W 8

// Instructions per fetch group, one prediction each
`define BP_SLOTS 4

`endif

/* logic/bpRepairPkg.sv */
// Base predictor types: scalar widths plus the checkpoint and update bundle of the repair path
`include "bp_defines.svh"

package bpRepairPkg;

    // ------------------------------
    // Scalar widths
    // ------------------------------

    // Virtual address of a fetch group or branch
    typedef logic [`BP_ADDR_W-1:0] vAddr_t;

    // Global history, newest outcome in bit 0
    typedef logic [`BP_HIST_W-1:0] history_t;

    // Two-bit saturating counter, MSB is the taken guess
    typedef logic [1:0] counter_t;

    // ------------------------------
    // Update side
    // ------------------------------

    // State captured at prediction time
    // Handed back later to rebuild history and train
    typedef struct packed {
        history_t hist;
        counter_t ctr;
    } checkpoint_t;

    // What a later stage asks of the predictor
    typedef enum logic [1:0] {
        ACT_NONE      = 2'd0,
        ACT_SPECULATE = 2'd1,
        ACT_REPAIR    = 2'd2,
        ACT_TRAIN     = 2'd3
    } repairAction_e;

    // One update per cycle, strobed by a non-NONE action
    typedef struct packed {
        repairAction_e action;
        checkpoint_t   checkpoint;
        vAddr_t        pc;
        logic          taken;
    } updateBundle_t;

endpackage

/* logic/bpFetchPkg.sv */
// Lookup-side predictor types: table index and the per-fetch-group prediction bundle
`include "bp_defines.svh"

package bpFetchPkg;

    // ------------------------------
    // Table addressing
    // ------------------------------

    // Counter table index, result of the pc and history hash
    typedef logic [`BP_IDX_W-1:0] phtIdx_t;

    // ------------------------------
    // Prediction output
    // ------------------------------

    // One lookup covers the whole fetch group
    // Bit i of takenMask belongs to slot i
    // Checkpoint i holds history used and counter read for slot i
    typedef struct packed {
        logic [`BP_SLOTS-1:0]                     takenMask;
        bpRepairPkg::checkpoint_t [`BP_SLOTS-1:0] checkpoints;
    } predBundle_t;

    // Index of slot zero before hashing
    // Word address of the fetch group base
    function automatic phtIdx_t baseIdx(input bpRepairPkg::vAddr_t pc);
        baseIdx = pc[`BP_IDX_W+1:2];
    endfunction

    // Gshare hash of a word index and a history
    function automatic phtIdx_t hashIdx(
        input phtIdx_t                word,
        input bpRepairPkg::history_t  hist
    );
        hashIdx = word ^ hist;
    endfunction

endpackage

/* logic/globalHistory.sv */
// Speculative global branch history register, shifted on speculation and rebuilt on repair
`timescale 1ns/1ns
`include "bp_defines.svh"

module globalHistory (
    input  logic                       clk,
    input  logic                       rst,
    // Update strobe from the later pipeline stage
    input  bpRepairPkg::updateBundle_t update_i,
    // Current speculative history, feeds the table hash
    output bpRepairPkg::history_t      history_o
);

    // ------------------------------
    // History state
    // ------------------------------

    bpRepairPkg::history_t historyQ;
    bpRepairPkg::history_t historyNext;

    // Next history per action
    always_comb begin
        historyNext = historyQ;
        case (update_i.action)
            // Push predicted outcome onto live history
            bpRepairPkg::ACT_SPECULATE: begin
                historyNext = {historyQ[`BP_HIST_W-2:0], update_i.taken};
            end
            // Drop wrong-path outcomes
            // restart from checkpoint plus the resolved outcome
            bpRepairPkg::ACT_REPAIR: begin
                historyNext = {update_i.checkpoint.hist[`BP_HIST_W-2:0], update_i.taken};
            end
            // TRAIN and NONE leave history alone
            default: begin
                historyNext = historyQ;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            historyQ <= '0;
        end else begin
            historyQ <= historyNext;
        end
    end

    // Same-cycle queries see the value from before the update
    assign history_o = historyQ;

    // ------------------------------
    // Checks
    // ------------------------------

    // Update action must be driven once out of reset
    // an X here corrupts both history and table
    actionKnown: assert property (
        @(posedge clk) disable iff (!rst)
        !$isunknown(update_i.action)
    ) else $error("globalHistory: update action is unknown");

endmodule

/* logic/patternHistoryTable.sv */
// Gshare counter table: four-slot registered lookup and saturating training from checkpoints
`timescale 1ns/1ns
`include "bp_defines.svh"

module patternHistoryTable (
    input  logic                       clk,
    input  logic                       rst,
    // Lookup side
    input  logic                       queryValid_i,
    input  bpRepairPkg::vAddr_t        queryPc_i,
    input  bpRepairPkg::history_t      history_i,
    // Update side
    input  bpRepairPkg::updateBundle_t update_i,
    // Prediction, one cycle after the query
    output logic                       predValid_o,
    output bpFetchPkg::predBundle_t    pred_o
);

    localparam int PHT_ENTRIES = 1 << `BP_IDX_W;

    // Weakly not-taken
    localparam bpRepairPkg::counter_t CTR_INIT = 2'd1;
    localparam bpRepairPkg::counter_t CTR_MAX  = 2'd3;
    localparam bpRepairPkg::counter_t CTR_MIN  = 2'd0;

    // ------------------------------
    // Counter storage
    // ------------------------------

    bpRepairPkg::counter_t phtMem [PHT_ENTRIES];

    // ------------------------------
    // Lookup
    // ------------------------------

    bpFetchPkg::phtIdx_t     slotIdx [`BP_SLOTS];
    bpRepairPkg::counter_t   slotCtr [`BP_SLOTS];
    bpFetchPkg::predBundle_t predNext;

    // Slot i sits one word past slot i-1
    // wraps inside the index width before the hash
    always_comb begin
        predNext = '0;
        for (int i = 0; i < `BP_SLOTS; i++) begin
            slotIdx[i] = bpFetchPkg::hashIdx(
                bpFetchPkg::phtIdx_t'(bpFetchPkg::baseIdx(queryPc_i) + i),
                history_i
            );
            slotCtr[i] = phtMem[slotIdx[i]];
            // Counter MSB is the direction
            predNext.takenMask[i]            = slotCtr[i][1];
            predNext.checkpoints[i].hist     = history_i;
            predNext.checkpoints[i].ctr      = slotCtr[i];
        end
    end

    // Valid strobe
    always_ff @(posedge clk) begin
        if (!rst) begin
            predValid_o <= 1'b0;
        end else begin
            predValid_o <= queryValid_i;
        end
    end

    // Payload held between queries
    always_ff @(posedge clk) begin
        if (queryValid_i) begin
            pred_o <= predNext;
        end
    end

    // ------------------------------
    // Training
    // ------------------------------

    logic                  trainEn;
    bpFetchPkg::phtIdx_t   trainIdx;
    bpRepairPkg::counter_t trainCtr;

    // Repair and train both write the table
    assign trainEn = (update_i.action == bpRepairPkg::ACT_REPAIR) ||
                     (update_i.action == bpRepairPkg::ACT_TRAIN);

    // Entry the branch read at prediction time
    assign trainIdx = bpFetchPkg::hashIdx(
        bpFetchPkg::baseIdx(update_i.pc),
        update_i.checkpoint.hist
    );

    // Start from checkpointed counter, not the live entry
    always_comb begin
        trainCtr = update_i.checkpoint.ctr;
        if (update_i.taken) begin
            if (update_i.checkpoint.ctr != CTR_MAX) begin
                trainCtr = update_i.checkpoint.ctr + 2'd1;
            end
        end else begin
            if (update_i.checkpoint.ctr != CTR_MIN) begin
                trainCtr = update_i.checkpoint.ctr - 2'd1;
            end
        end
    end

    // All entries reset together, no init sweep
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int e = 0; e < PHT_ENTRIES; e++) begin
                phtMem[e] <= CTR_INIT;
            end
        end else if (trainEn) begin
            phtMem[trainIdx] <= trainCtr;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Fixed one-cycle lookup latency, both directions
    predLatency: assert property (
        @(posedge clk) disable iff (!rst)
        queryValid_i |=> predValid_o
    ) else $error("patternHistoryTable: prediction missing one cycle after query");

    predNoSpurious: assert property (
        @(posedge clk) disable iff (!rst)
        predValid_o |-> $past(queryValid_i)
    ) else $error("patternHistoryTable: prediction without a query");

    // Taken training never lowers the stored entry below its checkpoint
    takenNoDrop: assert property (
        @(posedge clk) disable iff (!rst)
        (trainEn && update_i.taken) |=>
            (phtMem[$past(trainIdx)] >= $past(update_i.checkpoint.ctr))
    ) else $error("patternHistoryTable: taken training lowered a counter");

endmodule

/* logic/branchDirectionPredictor.sv */
// Top of the gshare direction predictor, joins the history register and the counter table
`timescale 1ns/1ns

module branchDirectionPredictor (
    input  logic                       clk,
    input  logic                       rst,
    // Fetch query strobe and group base address
    input  logic                       queryValid_i,
    input  bpRepairPkg::vAddr_t        queryPc_i,
    // Speculate, repair or train request
    input  bpRepairPkg::updateBundle_t update_i,
    // Four-slot prediction, next cycle
    output logic                       predValid_o,
    output bpFetchPkg::predBundle_t    pred_o
);

    // ------------------------------
    // History to table hash
    // ------------------------------

    bpRepairPkg::history_t history;

    // Speculative history, sees every update
    globalHistory ghr_i (
        .clk       (clk),
        .rst       (rst),
        .update_i  (update_i),
        .history_o (history)
    );

    // Counter table
    // same update drives training
    patternHistoryTable pht_i (
        .clk          (clk),
        .rst          (rst),
        .queryValid_i (queryValid_i),
        .queryPc_i    (queryPc_i),
        .history_i    (history),
        .update_i     (update_i),
        .predValid_o  (predValid_o),
        .pred_o       (pred_o)
    );

endmodule

/* dv/clockGen.sv */
// Testbench clock and active-low reset source, instanced once by the predictor testbench
`timescale 1ns/1ns

module clockGen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock, 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // Reset low across the first rising edges
    // Released on a falling edge, away from the DUT sampling edge
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

/* dv/bpTb.sv */
// Self-checking testbench for the gshare direction predictor, top of the simulation
`timescale 1ns/1ns
`include "bp_defines.svh"

module bpTb;

    localparam logic [1:0] KIND_QUERY   = 2'd0;
    localparam logic [1:0] KIND_UPDATE  = 2'd1;
    localparam logic [1:0] KIND_BOTH    = 2'd2;
    localparam int         PRED_TIMEOUT = 5;
    localparam int         RST_TIMEOUT  = 30;

    // Short names for the update actions
    localparam bpRepairPkg::repairAction_e NONE   = bpRepairPkg::ACT_NONE;
    localparam bpRepairPkg::repairAction_e SPEC   = bpRepairPkg::ACT_SPECULATE;
    localparam bpRepairPkg::repairAction_e REPAIR = bpRepairPkg::ACT_REPAIR;
    localparam bpRepairPkg::repairAction_e TRAIN  = bpRepairPkg::ACT_TRAIN;

    // One row of the stimulus table
    typedef struct packed {
        logic [2:0]                 testId;
        logic [1:0]                 kind;
        bpRepairPkg::vAddr_t        pc;
        bpRepairPkg::repairAction_e action;
        logic                       taken;
        // Checkpoint and branch pc taken from the last prediction of ckptSlot
        logic                       useCkpt;
        logic [1:0]                 ckptSlot;
    } stimEntry_t;

    logic                       clk;
    logic                       rst;
    logic                       queryValid;
    bpRepairPkg::vAddr_t        queryPc;
    bpRepairPkg::updateBundle_t update;
    logic                       predValid;
    bpFetchPkg::predBundle_t    pred;

    stimEntry_t              stimTable [$];
    bpRepairPkg::counter_t   modelCtr [1 << `BP_IDX_W];
    bpRepairPkg::history_t   modelHist;
    bpFetchPkg::predBundle_t lastExp;
    bpRepairPkg::vAddr_t     lastPc;
    int                      passCount;
    int                      failCount;
    int                      testChecks;
    int                      testErrors;
    logic                    timedOut;

    clockGen clkGen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    branchDirectionPredictor dut_i (
        .clk          (clk),
        .rst          (rst),
        .queryValid_i (queryValid),
        .queryPc_i    (queryPc),
        .update_i     (update),
        .predValid_o  (predValid),
        .pred_o       (pred)
    );

    // ------------------------------
    // Reference model
    // ------------------------------

    // Word index of slot, wrapped to table width, then gshare XOR
    function automatic bpFetchPkg::phtIdx_t modelIndex(
        input bpRepairPkg::vAddr_t   pc,
        input int                    slot,
        input bpRepairPkg::history_t hist
    );
        bpRepairPkg::vAddr_t word;
        word = (pc >> 2) + 32'(slot);
        return word[`BP_IDX_W-1:0] ^ hist;
    endfunction

    // Two-bit saturating step
    function automatic bpRepairPkg::counter_t nextCounter(
        input bpRepairPkg::counter_t ctr,
        input logic                  taken
    );
        if (taken) begin
            return (ctr == 2'd3) ? 2'd3 : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? 2'd0 : ctr - 2'd1;
    endfunction

    function automatic bpFetchPkg::predBundle_t predictModel(input bpRepairPkg::vAddr_t pc);
        bpFetchPkg::predBundle_t p;
        bpFetchPkg::phtIdx_t     idx;
        p = '0;
        for (int i = 0; i < `BP_SLOTS; i++) begin
            idx                   = modelIndex(pc, i, modelHist);
            p.takenMask[i]        = modelCtr[idx][1];
            p.checkpoints[i].hist = modelHist;
            p.checkpoints[i].ctr  = modelCtr[idx];
        end
        return p;
    endfunction

    task automatic applyModel(input bpRepairPkg::updateBundle_t upd);
        bpFetchPkg::phtIdx_t idx;
        idx = modelIndex(upd.pc, 0, upd.checkpoint.hist);
        case (upd.action)
            SPEC: begin
                modelHist = {modelHist[`BP_HIST_W-2:0], upd.taken};
            end
            REPAIR: begin
                modelHist     = {upd.checkpoint.hist[`BP_HIST_W-2:0], upd.taken};
                modelCtr[idx] = nextCounter(upd.checkpoint.ctr, upd.taken);
            end
            TRAIN: begin
                modelCtr[idx] = nextCounter(upd.checkpoint.ctr, upd.taken);
            end
            default: begin
            end
        endcase
    endtask

    // ------------------------------
    // Checking and reporting
    // ------------------------------

    task automatic checkValue(input string field, input logic [31:0] got, input logic [31:0] exp);
        testChecks++;
        assert (got === exp) begin
            passCount++;
        end else begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, field, got, exp);
            failCount++;
            testErrors++;
        end
    endtask

    function automatic string testName(input int id);
        case (id)
            1:       return "reset state";
            2:       return "speculation";
            3:       return "training";
            4:       return "repair";
            5:       return "same-cycle query and update";
            default: return "random mix";
        endcase
    endfunction

    task automatic reportTest(input int id);
        $display("Test %0d %s: %0d checks, %0d errors", id, testName(id), testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------

    task automatic addOp(
        input int                         testId,
        input logic [1:0]                 kind,
        input bpRepairPkg::vAddr_t        pc,
        input bpRepairPkg::repairAction_e action,
        input logic                       taken,
        input int                         slot
    );
        stimEntry_t e;
        e.testId   = 3'(testId);
        e.kind     = kind;
        e.pc       = pc;
        e.action   = action;
        e.taken    = taken;
        e.useCkpt  = (action == REPAIR) || (action == TRAIN);
        e.ckptSlot = 2'(slot);
        stimTable.push_back(e);
    endtask

    task automatic fillTable();
        logic [31:0]                rnd;
        bpRepairPkg::vAddr_t        rndPc;
        bpRepairPkg::repairAction_e act;
        logic [1:0]                 kindSel;
        // Fresh table, second group wraps the slot index
        addOp(1, KIND_QUERY, 32'h0000_1000, NONE, 1'b0, 0);
        addOp(1, KIND_QUERY, 32'h0000_13fc, NONE, 1'b0, 0);
        // Shift pattern 1,0 then 1,1
        addOp(2, KIND_UPDATE, 32'h0, SPEC, 1'b1, 0);
        addOp(2, KIND_UPDATE, 32'h0, SPEC, 1'b0, 0);
        addOp(2, KIND_QUERY, 32'h0000_1000, NONE, 1'b0, 0);
        addOp(2, KIND_UPDATE, 32'h0, SPEC, 1'b1, 0);
        addOp(2, KIND_UPDATE, 32'h0, SPEC, 1'b1, 0);
        addOp(2, KIND_QUERY, 32'h0000_2040, NONE, 1'b0, 0);
        // Slot 2 counter up to 3 and held, then down to 0 and held
        for (int k = 0; k < 8; k++) begin
            addOp(3, KIND_QUERY, 32'h0000_3000, NONE, 1'b0, 0);
            addOp(3, KIND_UPDATE, 32'h0, TRAIN, k < 4, 2);
        end
        addOp(3, KIND_QUERY, 32'h0000_3000, NONE, 1'b0, 0);
        // Wrong-path shifts then repair from the older checkpoint
        addOp(4, KIND_QUERY, 32'h0000_4000, NONE, 1'b0, 0);
        addOp(4, KIND_UPDATE, 32'h0, SPEC, 1'b1, 0);
        addOp(4, KIND_UPDATE, 32'h0, SPEC, 1'b1, 0);
        addOp(4, KIND_UPDATE, 32'h0, SPEC, 1'b0, 0);
        addOp(4, KIND_UPDATE, 32'h0, REPAIR, 1'b1, 1);
        addOp(4, KIND_QUERY, 32'h0000_4000, NONE, 1'b0, 0);
        // Slot 0 of this group hashes onto the repaired entry under the new history
        addOp(4, KIND_QUERY, 32'h0000_4074, NONE, 1'b0, 0);
        // Query and update in one cycle, old state seen first
        addOp(5, KIND_QUERY, 32'h0000_5000, NONE, 1'b0, 0);
        addOp(5, KIND_BOTH, 32'h0000_5000, TRAIN, 1'b1, 0);
        addOp(5, KIND_QUERY, 32'h0000_5000, NONE, 1'b0, 0);
        addOp(5, KIND_BOTH, 32'h0000_5000, SPEC, 1'b1, 0);
        addOp(5, KIND_QUERY, 32'h0000_5000, NONE, 1'b0, 0);
        // Queries weighted two to one, pcs kept small for aliasing
        for (int k = 0; k < 60; k++) begin
            rnd     = $urandom;
            rndPc   = $urandom & 32'h0000_0ffc;
            act     = (rnd[3:2] == 2'd0) ? SPEC : (rnd[3:2] == 2'd1) ? REPAIR : TRAIN;
            kindSel = (rnd[1:0] == 2'd3) ? KIND_BOTH :
                      (rnd[1:0] == 2'd2) ? KIND_UPDATE : KIND_QUERY;
            addOp(6, kindSel, rndPc, act, rnd[4], int'(rnd[6:5]));
        end
    endtask

    // ------------------------------
    // One table row, driven on the falling edge
    // ------------------------------

    task automatic runStep(input stimEntry_t op);
        bpRepairPkg::updateBundle_t upd;
        bpFetchPkg::predBundle_t    expPred;
        logic                       isQuery;
        logic                       isUpdate;
        int                         waited;
        isQuery  = (op.kind == KIND_QUERY) || (op.kind == KIND_BOTH);
        isUpdate = (op.kind == KIND_UPDATE) || (op.kind == KIND_BOTH);
        upd      = '0;
        expPred  = '0;
        if (isUpdate) begin
            upd.action = op.action;
            upd.taken  = op.taken;
            upd.pc     = op.pc;
            // Branch pc of the slot in the last fetch group
            if (op.useCkpt) begin
                upd.checkpoint = lastExp.checkpoints[op.ckptSlot];
                upd.pc         = lastPc + {28'd0, op.ckptSlot, 2'b00};
            end
        end
        queryValid = isQuery;
        queryPc    = op.pc;
        update     = upd;
        // Expected value from pre-update model state
        if (isQuery) begin
            expPred = predictModel(op.pc);
        end
        if (isUpdate) begin
            applyModel(upd);
        end
        @(posedge clk);
        @(negedge clk);
        queryValid = 1'b0;
        update     = '0;
        if (!isQuery) begin
            checkValue("predValid_o without query", 32'(predValid), 32'd0);
            return;
        end
        waited = 0;
        while (!predValid && waited < PRED_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!predValid) begin
            $display("No prediction arrived within %0d cycles of the query at %0t ns",
                     PRED_TIMEOUT, $time);
            timedOut = 1'b1;
            return;
        end
        checkValue("prediction latency", 32'(waited), 32'd0);
        checkValue("takenMask", 32'(pred.takenMask), 32'(expPred.takenMask));
        for (int i = 0; i < `BP_SLOTS; i++) begin
            checkValue($sformatf("slot %0d checkpoint hist", i),
                       32'(pred.checkpoints[i].hist), 32'(expPred.checkpoints[i].hist));
            checkValue($sformatf("slot %0d checkpoint ctr", i),
                       32'(pred.checkpoints[i].ctr), 32'(expPred.checkpoints[i].ctr));
        end
        lastExp = expPred;
        lastPc  = op.pc;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int waited;
        int curTest;
        queryValid = 1'b0;
        queryPc    = '0;
        update     = '0;
        passCount  = 0;
        failCount  = 0;
        testChecks = 0;
        testErrors = 0;
        timedOut   = 1'b0;
        lastExp    = '0;
        lastPc     = '0;
        void'($urandom(32'h4c94af64));
        // Model reset, weakly not-taken everywhere
        foreach (modelCtr[e]) begin
            modelCtr[e] = 2'd1;
        end
        modelHist = '0;
        fillTable();
        // Reset release, sampled on rising edges
        waited = 0;
        while (rst !== 1'b1 && waited < RST_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b1) begin
            $display("Reset was never released within %0d cycles", RST_TIMEOUT);
            timedOut = 1'b1;
        end else begin
            @(negedge clk);
            checkValue("predValid_o after reset", 32'(predValid), 32'd0);
            curTest = int'(stimTable[0].testId);
            for (int n = 0; n < stimTable.size(); n++) begin
                if (int'(stimTable[n].testId) != curTest) begin
                    reportTest(curTest);
                    curTest = int'(stimTable[n].testId);
                end
                runStep(stimTable[n]);
                if (timedOut) begin
                    break;
                end
            end
            reportTest(curTest);
        end
        $display("Summary: %0d checks passed, %0d checks failed", passCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
logic/bpRepairPkg.sv
logic/bpFetchPkg.sv
logic/globalHistory.sv
logic/patternHistoryTable.sv
logic/branchDirectionPredictor.sv
dv/clockGen.sv
dv/bpTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the gshare predictor testbench with Verilator, run it, and scan the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f all.f --top-module bpTb -Mdir "$BUILD_DIR" -o bpSim
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

"./$BUILD_DIR/bpSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Regression failed" "$LOG_FILE"; then
    exit 1
fi
exit 0
